// ==== source/rgmii_pkg.sv ====
package rgmii_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] length_t;

    // Ethernet + IPv4 + UDP header with the first byte on the wire in the top bits
    typedef struct packed {
        mac_addr_t   mac_destination;
        mac_addr_t   mac_source;
        logic [15:0] ethertype;
        byte_t       version_ihl;
        byte_t       tos;
        length_t     total_length;
        logic [15:0] identification;
        logic [15:0] flags_fragment;
        byte_t       ttl;
        byte_t       protocol;
        logic [15:0] ip_checksum;
        logic [31:0] ip_source;
        logic [31:0] ip_destination;
        logic [15:0] udp_source_port;
        logic [15:0] udp_destination_port;
        length_t     udp_length;
        logic [15:0] udp_checksum;
    } header_t;

    typedef struct packed {
        byte_t data;
        logic  last;
    } stream_beat_t;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE_SFD,
        HEADER,
        PAYLOAD,
        FCS
    } rx_state_t;

    localparam int HEADER_BYTES        = 42;
    localparam int FCS_BYTES           = 4;
    localparam int IP_UDP_HEADER_BYTES = 28; // IPv4 + UDP headers inside total_length

    // Seven 0x55 then 0xD5 with the oldest byte in the top bits of the window
    localparam logic [63:0] PREAMBLE_SFD_WORD = 64'h5555_5555_5555_55D5;

endpackage

// ==== source/rx_input_delay.sv ====
`timescale 1ns/1ns

module rx_input_delay
    import rgmii_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,

    input  byte_t rx_d_i,
    input  logic  rx_dv_i,

    output byte_t rx_byte_o,
    output logic  frame_start_o,
    output logic  frame_end_o
);

    byte_t [2:0] rxd_z;
    logic  [2:0] rxdv_z;

    always_ff @(posedge clk_i) begin
        rxd_z <= {rxd_z[1:0], rx_d_i};
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxdv_z <= '0;
        end else begin
            rxdv_z <= {rxdv_z[1:0], rx_dv_i};
        end
    end

    assign rx_byte_o = rxd_z[2];

    // Edges seen one stage ahead so control switches state in step with rx_byte_o
    assign frame_start_o = !rxdv_z[2] && rxdv_z[1];
    assign frame_end_o   = rxdv_z[2] && !rxdv_z[1];

endmodule

// ==== source/rx_frame_ctrl.sv ====
`timescale 1ns/1ns

module rx_frame_ctrl
    import rgmii_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    input  logic      frame_start_i,
    input  logic      frame_end_i,
    input  logic      sfd_found_i,
    input  length_t   payload_len_i,

    output rx_state_t state_o,
    output logic      payload_last_o
);

    localparam length_t HEADER_END = length_t'(HEADER_BYTES - 1);
    localparam length_t FCS_END    = length_t'(FCS_BYTES - 1);

    rx_state_t state_q;
    rx_state_t state_d;
    length_t   count_q;  // Cycles spent in the current state
    length_t   payload_end;

    assign payload_end = payload_len_i - 16'd1;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (frame_start_i) begin
                    state_d = PREAMBLE_SFD;
                end
            end
            PREAMBLE_SFD: begin
                if (sfd_found_i) begin
                    state_d = HEADER;
                end
                if (frame_end_i) begin
                    state_d = IDLE;
                end
            end
            HEADER: begin
                if (count_q == HEADER_END) begin
                    // Empty datagram skips straight to the FCS
                    if (payload_len_i == '0) begin
                        state_d = FCS;
                    end else begin
                        state_d = PAYLOAD;
                    end
                end
                if (frame_end_i) begin
                    state_d = IDLE;  // Frame cut short
                end
            end
            PAYLOAD: begin
                if (count_q == payload_end) begin
                    state_d = FCS;
                end
            end
            FCS: begin
                if (count_q == FCS_END) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (state_q != state_d) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 16'd1;
        end
    end

    assign state_o        = state_q;
    assign payload_last_o = (state_q == PAYLOAD) && (state_d == FCS);

endmodule

// ==== source/frame_header_capture.sv ====
`timescale 1ns/1ns

module frame_header_capture
    import rgmii_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,

    input  rx_state_t    state_i,
    input  logic         payload_last_i,
    input  byte_t        rx_byte_i,
    input  mac_addr_t    host_mac_i,

    output logic         sfd_found_o,
    output length_t      payload_len_o,
    output logic         wr_en_o,
    output stream_beat_t wr_beat_o
);

    localparam int HEADER_BITS = HEADER_BYTES * 8;

    logic [63:0] window_q;
    logic [63:0] window_d;
    header_t     header_q;
    header_t     header_d;

    assign window_d    = {window_q[55:0], rx_byte_i};
    assign sfd_found_o = (window_d == PREAMBLE_SFD_WORD);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            window_q <= '0;
        end else if (state_i == IDLE) begin
            window_q <= '0;  // No leftovers from an aborted frame
        end else if (state_i == PREAMBLE_SFD) begin
            window_q <= window_d;
        end
    end

    // Header seen with the current byte already shifted in, so the length
    // is ready in the last HEADER cycle
    always_comb begin
        header_d = header_q;
        if (state_i == HEADER) begin
            header_d = {header_q[HEADER_BITS-9:0], rx_byte_i};
        end
    end

    always_ff @(posedge clk_i) begin
        header_q <= header_d;
    end

    assign payload_len_o = header_d.total_length - length_t'(IP_UDP_HEADER_BYTES);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= (state_i == PAYLOAD) && (header_q.mac_destination == host_mac_i);
        end
    end

    always_ff @(posedge clk_i) begin
        wr_beat_o.data <= rx_byte_i;
        wr_beat_o.last <= payload_last_i;
    end

endmodule

// ==== source/payload_fifo.sv ====
`timescale 1ns/1ns

module payload_fifo
    import rgmii_pkg::*;
#(
    parameter int FIFO_ADDR_WIDTH = 11
) (
    input  logic         clk_i,
    input  logic         rst_i,

    input  logic         wr_en_i,
    input  stream_beat_t wr_beat_i,

    output stream_beat_t rd_beat_o,
    output logic         rd_valid_o,
    input  logic         rd_ready_i
);

    localparam int DEPTH = 2 ** FIFO_ADDR_WIDTH;

    stream_beat_t mem [DEPTH];

    // One extra bit tells full from empty
    logic [FIFO_ADDR_WIDTH:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr;
    logic                     full;
    logic                     empty;
    logic                     do_write;
    logic                     do_load;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH])
                && (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);

    assign do_write = wr_en_i && !full;  // Receiver cannot stall so overflow is lost
    assign do_load  = !empty && (!rd_valid_o || rd_ready_i);

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= wr_beat_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr <= '0;
        end else if (do_load) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Output register refilled when empty or being taken
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_valid_o <= 1'b0;
        end else if (do_load) begin
            rd_valid_o <= 1'b1;
        end else if (rd_ready_i) begin
            rd_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_load) begin
            rd_beat_o <= mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
        end
    end

endmodule

// ==== source/packet_recv.sv ====
`timescale 1ns/1ns

module packet_recv
    import rgmii_pkg::*;
#(
    parameter int FIFO_ADDR_WIDTH = 11
) (
    input  logic         clk_i,
    input  logic         rst_i,

    input  byte_t        rx_d_i,
    input  logic         rx_dv_i,
    input  mac_addr_t    host_mac_i,

    output stream_beat_t m_beat_o,
    output logic         m_tvalid_o,
    input  logic         m_tready_i
);

    byte_t        rx_byte;
    logic         frame_start;
    logic         frame_end;
    rx_state_t    state;
    logic         payload_last;
    logic         sfd_found;
    length_t      payload_len;
    logic         wr_en;
    stream_beat_t wr_beat;

    rx_input_delay i_rx_input_delay (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rx_d_i       (rx_d_i),
        .rx_dv_i      (rx_dv_i),
        .rx_byte_o    (rx_byte),
        .frame_start_o(frame_start),
        .frame_end_o  (frame_end)
    );

    rx_frame_ctrl i_rx_frame_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .frame_start_i (frame_start),
        .frame_end_i   (frame_end),
        .sfd_found_i   (sfd_found),
        .payload_len_i (payload_len),
        .state_o       (state),
        .payload_last_o(payload_last)
    );

    frame_header_capture i_frame_header_capture (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .state_i       (state),
        .payload_last_i(payload_last),
        .rx_byte_i     (rx_byte),
        .host_mac_i    (host_mac_i),
        .sfd_found_o   (sfd_found),
        .payload_len_o (payload_len),
        .wr_en_o       (wr_en),
        .wr_beat_o     (wr_beat)
    );

    payload_fifo #(
        .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
    ) i_payload_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_en_i   (wr_en),
        .wr_beat_i (wr_beat),
        .rd_beat_o (m_beat_o),
        .rd_valid_o(m_tvalid_o),
        .rd_ready_i(m_tready_i)
    );

endmodule

// ==== verif/packet_recv_tb.sv ====
`timescale 1ns/1ns

module packet_recv_tb
    import rgmii_pkg::*;
();

    localparam mac_addr_t HOST_MAC      = 48'h02_00_5E_10_20_30;
    localparam mac_addr_t PEER_MAC      = 48'h02_00_5E_77_88_99;
    localparam int        DRAIN_TIMEOUT = 50000;
    localparam int        IDLE_CYCLES   = 100;

    logic         clk_i;
    logic         rst_i;
    byte_t        rx_d_i;
    logic         rx_dv_i;
    mac_addr_t    host_mac;
    stream_beat_t m_beat;
    logic         m_tvalid;
    logic         m_tready;

    stream_beat_t exp_q[$];  // Beats the DUT still owes

    packet_recv #(
        .FIFO_ADDR_WIDTH(11)
    ) dut0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rx_d_i    (rx_d_i),
        .rx_dv_i   (rx_dv_i),
        .host_mac_i(host_mac),
        .m_beat_o  (m_beat),
        .m_tvalid_o(m_tvalid),
        .m_tready_i(m_tready)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_beat(input stream_beat_t got, input stream_beat_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf(
                "Mismatch at %0t: m_beat_o got data %h last %b, expected data %h last %b",
                $time, got.data, got.last, exp.data, exp.last));
        end
    endtask

    task automatic compare_level(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0t: %s got %b, expected %b",
                                      $time, name, got, exp));
        end
    endtask

    // Preamble, SFD, UDP header, payload and FCS that may be cut short
    task automatic send_frame(input mac_addr_t dest, input int len, input int accept,
                              input byte_t first, input byte_t step, input int trunc);
        header_t      hdr;
        byte_t        frame_q[$];
        byte_t        data;
        stream_beat_t beat;
        int           i;
        int           count;
        int           gap;

        for (i = 0; i < 7; i++) begin
            frame_q.push_back(8'h55);
        end
        frame_q.push_back(8'hD5);

        hdr                      = '0;
        hdr.mac_destination      = dest;
        hdr.mac_source           = PEER_MAC;
        hdr.ethertype            = 16'h0800;
        hdr.version_ihl          = 8'h45;
        hdr.total_length         = length_t'(len + 28);  // IPv4 + UDP headers + payload
        hdr.ttl                  = 8'h40;
        hdr.protocol             = 8'h11;
        hdr.ip_source            = 32'hC0A8_0102;
        hdr.ip_destination       = 32'hC0A8_0101;
        hdr.udp_source_port      = 16'd5000;
        hdr.udp_destination_port = 16'd6000;
        hdr.udp_length           = length_t'(len + 8);
        for (i = HEADER_BYTES - 1; i >= 0; i--) begin
            frame_q.push_back(hdr[i*8 +: 8]);  // Wire order with the top byte first
        end

        for (i = 0; i < len; i++) begin
            data = byte_t'(first + i * step);
            frame_q.push_back(data);
            if (accept != 0) begin
                beat.data = data;
                beat.last = (i == len - 1);
                exp_q.push_back(beat);
            end
        end

        for (i = 0; i < 4; i++) begin
            frame_q.push_back(byte_t'($urandom));  // FCS is not checked by the DUT
        end

        count = frame_q.size();
        if (trunc != 0 && trunc < count) begin
            count = trunc;
        end
        for (i = 0; i < count; i++) begin
            @(posedge clk_i);
            rx_d_i  <= frame_q[i];
            rx_dv_i <= 1'b1;
        end

        gap = 2 + int'($urandom % 8);
        @(posedge clk_i);
        rx_d_i  <= 8'h00;
        rx_dv_i <= 1'b0;
        repeat (gap - 1) @(posedge clk_i);
    endtask

    // Consumer with random back-pressure
    initial begin
        m_tready = 1'b0;
        forever begin
            @(posedge clk_i);
            m_tready <= (($urandom % 10) < 7);
        end
    end

    always @(posedge clk_i) begin
        if (!rst_i && m_tvalid && m_tready) begin
            if (exp_q.size() == 0) begin
                stop_with_error($sformatf("Unexpected beat at %0t: data %h with none outstanding",
                                          $time, m_beat.data));
            end else begin
                check_beat(m_beat, exp_q.pop_front());
            end
        end
    end

    initial begin
        int        fd;
        int        n;
        int        frames;
        int        wait_cycles;
        string     line;
        mac_addr_t dest;
        int        len;
        int        accept;
        int        first;
        int        step;
        int        trunc;

        void'($urandom(55));
        rst_i    = 1'b1;
        rx_d_i   = 8'h00;
        rx_dv_i  = 1'b0;
        host_mac = HOST_MAC;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;

        fd = $fopen("verif/packet_recv_tests.txt", "r");
        if (fd == 0) begin
            stop_with_error("Could not open the frame list verif/packet_recv_tests.txt");
        end
        frames = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %d %d %h %h %d", dest, len, accept, first, step, trunc);
            if (n == 6) begin  // Comment and blank lines fall through
                send_frame(dest, len, accept, byte_t'(first), byte_t'(step), trunc);
                frames++;
            end
        end
        $fclose(fd);
        if (frames == 0) begin
            stop_with_error("The frame list holds no frames");
        end

        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            stop_with_error($sformatf("Timed out with %0d payload beats never delivered",
                                      exp_q.size()));
        end else begin
            // Nothing more may come out once all frames are drained
            repeat (IDLE_CYCLES) begin
                @(posedge clk_i);
                compare_level(m_tvalid, 1'b0, "m_tvalid_o");
            end

            $display("%0d frames sent", frames);
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// ==== packet_recv.f ====
source/rgmii_pkg.sv
source/rx_input_delay.sv
source/rx_frame_ctrl.sv
source/frame_header_capture.sv
source/payload_fifo.sv
source/packet_recv.sv
verif/packet_recv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the GMII/UDP receiver testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal \
    --top-module packet_recv_tb \
    -f packet_recv.f \
    -o packet_recv_sim

# A $fatal in the testbench gives a non-zero exit status here
./obj_dir/packet_recv_sim

// ==== verif/packet_recv_tests.txt ====
# dest_mac(hex) payload_len(dec) accept(0/1) first_byte(hex) step(hex) trunc(dec, 0 = full frame)
# Host MAC is 02005e102030; payload byte k = first + k*step mod 256
02005e102030 16 1 00 01 0
02005e102031 40 0 10 01 0
02005e102030 1 1 a5 00 0
ffffffffffff 64 0 33 03 0
02005e102030 60 1 80 07 0
02005e102030 100 0 00 01 5
02005e102030 8 1 11 11 0
02005e102030 100 0 00 01 30
02005e102030 32 1 f0 01 0
02005e102030 0 1 00 00 0
02005e102030 2 1 fe 01 0
02005e102030 300 1 00 01 0
12005e102030 300 0 55 01 0
02005e102030 50 0 d5 01 50
02005e102030 255 1 01 02 0
02005e102030 3 1 55 00 0
02005e102030 200 0 00 01 8
02005e102030 128 1 ff ff 0
02005e102031 5 0 00 01 0
02005e102030 7 1 d5 55 0
02005e102030 299 1 7f 03 0
02005e102030 1 1 00 00 0
02005e102030 64 1 aa 01 0
02005e102030 10 0 00 01 12
02005e102030 150 1 20 05 0
02005e102030 20 1 00 01 0
02005e10ffff 0 0 00 00 0
02005e102030 300 1 c3 0d 0
